//--- design/hyb_cache_pkg.sv
/* Shared sizes, lookup key layout and fully-associative set hash
   for the two-mode 4-way cache memory */
`default_nettype none

package hyb_cache_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned NUM_WAYS       = 4;
  localparam int unsigned WAY_IDX_W      = $clog2(NUM_WAYS);
  localparam int unsigned NUM_SETS       = 64;
  localparam int unsigned SET_W          = $clog2(NUM_SETS);
  localparam int unsigned SA_TAG_W       = 20;
  // Key is set index on top of the tag
  localparam int unsigned KEY_W          = SET_W + SA_TAG_W;

  localparam int unsigned WORD_W         = 32;
  localparam int unsigned WORDS_PER_LINE = 4;
  localparam int unsigned LINE_W         = WORDS_PER_LINE * WORD_W;
  localparam int unsigned OFF_W          = $clog2(WORDS_PER_LINE);

  // Reserved data region for fully-associative lines
  localparam int unsigned FA_BASE_SET    = 48;
  localparam int unsigned FA_SET_COUNT   = 16;
  localparam int unsigned FA_SET_W       = $clog2(FA_SET_COUNT);

  localparam logic [KEY_W-1:0] HASH_SEED = 26'h2A5F0C3;

  ////////////////////////////////////////////////////////////
  // Lookup key, seen per mode
  ////////////////////////////////////////////////////////////

  typedef union packed {
    // Set-associative split
    struct packed {
      logic [SET_W-1:0]    set;
      logic [SA_TAG_W-1:0] tag;
    } sa;
    // Whole key is the associative tag
    logic [KEY_W-1:0] fa;
  } hyb_key_u;

  // Hash a full key into the reserved region
  function automatic logic [SET_W-1:0] hyb_fa_set(input logic [KEY_W-1:0] key);
    logic [KEY_W-1:0] mix;
    mix = key ^ HASH_SEED ^ (key >> 2);
    return SET_W'(FA_BASE_SET) + SET_W'(mix[FA_SET_W-1:0]);
  endfunction

endpackage

`default_nettype wire

//--- design/hyb_tag_store.sv
/* Tag, valid and associative lookup table storage with set resolution,
   write gating during flush and one-hot hit detection */
`default_nettype none

module hyb_tag_store (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_ni,
  input  wire logic                                      set_assoc_mode_i,
  input  wire logic                                      rd_req_i,
  input  hyb_cache_pkg::hyb_key_u                        rd_key_i,
  input  hyb_cache_pkg::hyb_key_u                        wr_cl_key_i,
  input  hyb_cache_pkg::hyb_key_u                        wr_word_key_i,
  input  wire logic                                      wr_cl_vld_i,
  input  wire logic [hyb_cache_pkg::NUM_WAYS-1:0]        wr_cl_we_i,
  input  wire logic [hyb_cache_pkg::NUM_WAYS-1:0]        wr_cl_vld_bits_i,
  input  wire logic                                      wr_word_en_i,
  input  wire logic                                      flushing_i,
  input  wire logic [hyb_cache_pkg::SET_W-1:0]           flush_set_i,
  input  wire logic                                      flush_start_i,
  output logic      [hyb_cache_pkg::SET_W-1:0]           rd_set_o,
  output logic      [hyb_cache_pkg::SET_W-1:0]           cl_set_o,
  output logic      [hyb_cache_pkg::SET_W-1:0]           word_set_o,
  output logic                                           wr_cl_en_o,
  output logic                                           wr_word_en_o,
  output logic      [hyb_cache_pkg::NUM_WAYS-1:0]        hit_oh_o,
  output logic      [hyb_cache_pkg::NUM_WAYS-1:0]        vld_bits_o
);

  // Tag and valid arrays, one row per set
  logic [hyb_cache_pkg::SA_TAG_W-1:0] tag_mem   [hyb_cache_pkg::NUM_SETS][hyb_cache_pkg::NUM_WAYS];
  logic [hyb_cache_pkg::NUM_WAYS-1:0] valid_mem [hyb_cache_pkg::NUM_SETS];

  // Associative table, entry index equals way
  logic [hyb_cache_pkg::KEY_W-1:0]    fa_key_q  [hyb_cache_pkg::NUM_WAYS];
  logic [hyb_cache_pkg::NUM_WAYS-1:0] fa_vld_q;

  ////////////////////////////////////////////////////////////
  // Set resolution and write acceptance
  ////////////////////////////////////////////////////////////

  // Set field directly, or hashed into the reserved region
  assign rd_set_o   = set_assoc_mode_i ? rd_key_i.sa.set
                                       : hyb_cache_pkg::hyb_fa_set(rd_key_i.fa);
  assign cl_set_o   = set_assoc_mode_i ? wr_cl_key_i.sa.set
                                       : hyb_cache_pkg::hyb_fa_set(wr_cl_key_i.fa);
  assign word_set_o = set_assoc_mode_i ? wr_word_key_i.sa.set
                                       : hyb_cache_pkg::hyb_fa_set(wr_word_key_i.fa);

  // Writes are dropped while the flush walker runs
  assign wr_cl_en_o   = wr_cl_vld_i && !flushing_i;
  assign wr_word_en_o = wr_word_en_i && !flushing_i;

  ////////////////////////////////////////////////////////////
  // Valid state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < hyb_cache_pkg::NUM_SETS; s++) begin
        valid_mem[s] <= '0;
      end
      fa_vld_q <= '0;
    end else begin
      // One set per flushing cycle
      if (flushing_i) begin
        valid_mem[flush_set_i] <= '0;
      end
      // Whole table goes on the first cycle
      if (flush_start_i) begin
        fa_vld_q <= '0;
      end
      if (wr_cl_en_o) begin
        for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
          if (wr_cl_we_i[w]) begin
            if (set_assoc_mode_i) begin
              valid_mem[cl_set_o][w] <= wr_cl_vld_bits_i[w];
            end else begin
              fa_vld_q[w] <= wr_cl_vld_bits_i[w];
            end
          end
        end
      end
    end
  end

  // Tags and table keys only change on a line write
  always_ff @(posedge clk_i) begin
    if (wr_cl_en_o) begin
      for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
        if (wr_cl_we_i[w]) begin
          if (set_assoc_mode_i) begin
            tag_mem[cl_set_o][w] <= wr_cl_key_i.sa.tag;
          end else begin
            fa_key_q[w] <= wr_cl_key_i.fa;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
      if (set_assoc_mode_i) begin
        hit_oh_o[w] = rd_req_i && valid_mem[rd_set_o][w] &&
                      (tag_mem[rd_set_o][w] == rd_key_i.sa.tag);
      end else begin
        // Full key search over all table entries
        hit_oh_o[w] = rd_req_i && fa_vld_q[w] && (fa_key_q[w] == rd_key_i.fa);
      end
    end
  end

  assign vld_bits_o = set_assoc_mode_i ? valid_mem[rd_set_o] : fa_vld_q;

  // Fills never place one key in two ways
  a_hit_onehot0: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_oh_o)
  );

endmodule

`default_nettype wire

//--- design/hyb_data_store.sv
/* Line data array with whole-line and single-word writes
   and the hit-way word read mux */
`default_nettype none

module hyb_data_store (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  input  wire logic [hyb_cache_pkg::SET_W-1:0]      rd_set_i,
  input  wire logic [hyb_cache_pkg::OFF_W-1:0]      rd_off_i,
  input  wire logic [hyb_cache_pkg::NUM_WAYS-1:0]   hit_oh_i,
  input  wire logic                                 wr_cl_en_i,
  input  wire logic [hyb_cache_pkg::NUM_WAYS-1:0]   wr_cl_we_i,
  input  wire logic [hyb_cache_pkg::SET_W-1:0]      cl_set_i,
  input  wire logic [hyb_cache_pkg::LINE_W-1:0]     wr_cl_data_i,
  input  wire logic                                 wr_word_en_i,
  input  wire logic [hyb_cache_pkg::NUM_WAYS-1:0]   wr_word_we_i,
  input  wire logic [hyb_cache_pkg::SET_W-1:0]      word_set_i,
  input  wire logic [hyb_cache_pkg::OFF_W-1:0]      wr_word_off_i,
  input  wire logic [hyb_cache_pkg::WORD_W-1:0]     wr_word_data_i,
  output logic      [hyb_cache_pkg::WORD_W-1:0]     rd_data_o
);

  // 64 sets by 4 ways of full lines
  logic [hyb_cache_pkg::LINE_W-1:0] data_mem [hyb_cache_pkg::NUM_SETS][hyb_cache_pkg::NUM_WAYS];

  ////////////////////////////////////////////////////////////
  // Writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_cl_en_i) begin
      for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
        if (wr_cl_we_i[w]) begin
          data_mem[cl_set_i][w] <= wr_cl_data_i;
        end
      end
    end
    // Issued after the line write, so the word wins on overlap
    if (wr_word_en_i) begin
      for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
        if (wr_word_we_i[w]) begin
          data_mem[word_set_i][w][wr_word_off_i*hyb_cache_pkg::WORD_W +: hyb_cache_pkg::WORD_W]
            <= wr_word_data_i;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  // Zero unless a way hits
  always_comb begin
    rd_data_o = '0;
    for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
      if (hit_oh_i[w]) begin
        rd_data_o = data_mem[rd_set_i][w][rd_off_i*hyb_cache_pkg::WORD_W +: hyb_cache_pkg::WORD_W];
      end
    end
  end

  // An accepted line strobe must name at least one way
  a_cl_we_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wr_cl_en_i |-> (|wr_cl_we_i)
  );

endmodule

`default_nettype wire

//--- design/hyb_victim_select.sv
/* Victim way choice, lowest invalid way first,
   otherwise a round-robin pointer advanced by accepted line writes */
`default_nettype none

module hyb_victim_select (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  input  wire logic [hyb_cache_pkg::NUM_WAYS-1:0]   vld_bits_i,
  input  wire logic                                 cl_accept_i,
  output logic      [hyb_cache_pkg::NUM_WAYS-1:0]   victim_oh_o
);

  logic [hyb_cache_pkg::WAY_IDX_W-1:0] rr_ptr_q;

  // Wraps naturally at the way count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else if (cl_accept_i) begin
      rr_ptr_q <= rr_ptr_q + 1'b1;
    end
  end

  always_comb begin
    victim_oh_o = '0;
    if (&vld_bits_i) begin
      // All ways taken
      victim_oh_o[rr_ptr_q] = 1'b1;
    end else begin
      // Scan down so the lowest free way is the last one kept
      for (int w = hyb_cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
        if (!vld_bits_i[w]) begin
          victim_oh_o    = '0;
          victim_oh_o[w] = 1'b1;
        end
      end
    end
  end

  // Exactly one way is offered for refill at all times
  a_victim_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot(victim_oh_o)
  );

endmodule

`default_nettype wire

//--- design/hyb_flush_ctrl.sv
/* Flush walker, steps one set per cycle over the region of the current mode
   and pulses an acknowledge after the last set */
`default_nettype none

module hyb_flush_ctrl (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              set_assoc_mode_i,
  input  wire logic                              flush_i,
  output logic                                   flushing_o,
  output logic                                   flush_start_o,
  output logic      [hyb_cache_pkg::SET_W-1:0]   flush_set_o,
  output logic                                   flush_ack_o
);

  logic [hyb_cache_pkg::SET_W-1:0] start_set;
  logic [hyb_cache_pkg::SET_W-1:0] end_set;

  // Whole array, or the reserved region only
  assign start_set = set_assoc_mode_i ? '0 : hyb_cache_pkg::SET_W'(hyb_cache_pkg::FA_BASE_SET);
  assign end_set   = set_assoc_mode_i ?
                     hyb_cache_pkg::SET_W'(hyb_cache_pkg::NUM_SETS - 1) :
                     hyb_cache_pkg::SET_W'(hyb_cache_pkg::FA_BASE_SET +
                                           hyb_cache_pkg::FA_SET_COUNT - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flushing_o    <= 1'b0;
      flush_start_o <= 1'b0;
      flush_set_o   <= '0;
      flush_ack_o   <= 1'b0;
    end else begin
      // Single cycle pulses by default
      flush_start_o <= 1'b0;
      flush_ack_o   <= 1'b0;
      if (flushing_o) begin
        flush_set_o <= flush_set_o + 1'b1;
        // Last set cleared on this edge
        if (flush_set_o == end_set) begin
          flushing_o  <= 1'b0;
          flush_ack_o <= 1'b1;
        end
      end else if (flush_i) begin
        flushing_o    <= 1'b1;
        flush_start_o <= 1'b1;
        flush_set_o   <= start_set;
      end
    end
  end

  // Acknowledge only follows a completed walk
  a_ack_not_flushing: assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_ack_o |-> !flushing_o
  );

endmodule

`default_nettype wire

//--- design/hyb_cache_mem.sv
/* Two-mode 4-way cache memory, set-associative or fully-associative
   lookup over shared tag, valid and data arrays */
`default_nettype none

module hyb_cache_mem (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  input  wire logic                                 set_assoc_mode_i,
  // Read side
  input  wire logic                                 rd_req_i,
  input  hyb_cache_pkg::hyb_key_u                   rd_key_i,
  input  wire logic [hyb_cache_pkg::OFF_W-1:0]      rd_off_i,
  output logic      [hyb_cache_pkg::NUM_WAYS-1:0]   rd_hit_oh_o,
  output logic      [hyb_cache_pkg::NUM_WAYS-1:0]   rd_vld_bits_o,
  output logic      [hyb_cache_pkg::WORD_W-1:0]     rd_data_o,
  // Line write
  input  wire logic                                 wr_cl_vld_i,
  input  wire logic [hyb_cache_pkg::NUM_WAYS-1:0]   wr_cl_we_i,
  input  hyb_cache_pkg::hyb_key_u                   wr_cl_key_i,
  input  wire logic [hyb_cache_pkg::NUM_WAYS-1:0]   wr_cl_vld_bits_i,
  input  wire logic [hyb_cache_pkg::LINE_W-1:0]     wr_cl_data_i,
  // Word write
  input  wire logic [hyb_cache_pkg::NUM_WAYS-1:0]   wr_word_we_i,
  input  hyb_cache_pkg::hyb_key_u                   wr_word_key_i,
  input  wire logic [hyb_cache_pkg::OFF_W-1:0]      wr_word_off_i,
  input  wire logic [hyb_cache_pkg::WORD_W-1:0]     wr_word_data_i,
  // Flush and refill
  input  wire logic                                 flush_i,
  output logic                                      flush_ack_o,
  output logic      [hyb_cache_pkg::NUM_WAYS-1:0]   victim_oh_o
);

  logic [hyb_cache_pkg::SET_W-1:0] rd_set;
  logic [hyb_cache_pkg::SET_W-1:0] cl_set;
  logic [hyb_cache_pkg::SET_W-1:0] word_set;
  logic                            wr_cl_en;
  logic                            wr_word_en;
  logic                            flushing;
  logic                            flush_start;
  logic [hyb_cache_pkg::SET_W-1:0] flush_set;

  hyb_tag_store i_hyb_tag_store (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .set_assoc_mode_i (set_assoc_mode_i),
    .rd_req_i         (rd_req_i),
    .rd_key_i         (rd_key_i),
    .wr_cl_key_i      (wr_cl_key_i),
    .wr_word_key_i    (wr_word_key_i),
    .wr_cl_vld_i      (wr_cl_vld_i),
    .wr_cl_we_i       (wr_cl_we_i),
    .wr_cl_vld_bits_i (wr_cl_vld_bits_i),
    .wr_word_en_i     (|wr_word_we_i),
    .flushing_i       (flushing),
    .flush_set_i      (flush_set),
    .flush_start_i    (flush_start),
    .rd_set_o         (rd_set),
    .cl_set_o         (cl_set),
    .word_set_o       (word_set),
    .wr_cl_en_o       (wr_cl_en),
    .wr_word_en_o     (wr_word_en),
    .hit_oh_o         (rd_hit_oh_o),
    .vld_bits_o       (rd_vld_bits_o)
  );

  hyb_data_store i_hyb_data_store (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rd_set_i       (rd_set),
    .rd_off_i       (rd_off_i),
    .hit_oh_i       (rd_hit_oh_o),
    .wr_cl_en_i     (wr_cl_en),
    .wr_cl_we_i     (wr_cl_we_i),
    .cl_set_i       (cl_set),
    .wr_cl_data_i   (wr_cl_data_i),
    .wr_word_en_i   (wr_word_en),
    .wr_word_we_i   (wr_word_we_i),
    .word_set_i     (word_set),
    .wr_word_off_i  (wr_word_off_i),
    .wr_word_data_i (wr_word_data_i),
    .rd_data_o      (rd_data_o)
  );

  // Pointer only moves on line writes that were not dropped
  hyb_victim_select i_hyb_victim_select (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .vld_bits_i  (rd_vld_bits_o),
    .cl_accept_i (wr_cl_en),
    .victim_oh_o (victim_oh_o)
  );

  hyb_flush_ctrl i_hyb_flush_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .set_assoc_mode_i (set_assoc_mode_i),
    .flush_i          (flush_i),
    .flushing_o       (flushing),
    .flush_start_o    (flush_start),
    .flush_set_o      (flush_set),
    .flush_ack_o      (flush_ack_o)
  );

endmodule

`default_nettype wire

//--- verif/hyb_cache_model.svh
/* Reference model of the two-mode cache, its expected read results
   and the typed compare tasks of the testbench */
`ifndef HYB_CACHE_MODEL_SVH
`define HYB_CACHE_MODEL_SVH

////////////////////////////////////////////////////////////
// Model state
////////////////////////////////////////////////////////////

logic [hyb_cache_pkg::SA_TAG_W-1:0]  m_tag    [hyb_cache_pkg::NUM_SETS][hyb_cache_pkg::NUM_WAYS];
logic [hyb_cache_pkg::NUM_WAYS-1:0]  m_vld    [hyb_cache_pkg::NUM_SETS];
logic [hyb_cache_pkg::LINE_W-1:0]    m_data   [hyb_cache_pkg::NUM_SETS][hyb_cache_pkg::NUM_WAYS];
// Associative table, entry w is way w
logic [hyb_cache_pkg::KEY_W-1:0]     m_fa_key [hyb_cache_pkg::NUM_WAYS];
logic [hyb_cache_pkg::NUM_WAYS-1:0]  m_fa_vld;
logic [hyb_cache_pkg::WAY_IDX_W-1:0] m_ptr;
logic                                m_sa;
// Read request level as driven
logic                                m_req;

function automatic void reset_model();
  for (int s = 0; s < hyb_cache_pkg::NUM_SETS; s++) begin
    m_vld[s] = '0;
  end
  m_fa_vld = '0;
  m_ptr    = '0;
  m_sa     = 1'b1;
  m_req    = 1'b0;
endfunction

// Set of a key in the current mode
function automatic logic [hyb_cache_pkg::SET_W-1:0] line_set(input hyb_cache_pkg::hyb_key_u key);
  logic [hyb_cache_pkg::KEY_W-1:0] h;
  h = key.fa ^ hyb_cache_pkg::HASH_SEED ^ (key.fa >> 2);
  if (m_sa) begin
    return key.sa.set;
  end
  // Sets 48 to 63 are the top quarter, upper two bits set
  return {2'b11, h[3:0]};
endfunction

// Expected hit, valid bits, word and victim for a read
function automatic void ref_read(input hyb_cache_pkg::hyb_key_u key,
                                 input logic [hyb_cache_pkg::OFF_W-1:0] off,
                                 output logic [hyb_cache_pkg::NUM_WAYS-1:0] hit,
                                 output logic [hyb_cache_pkg::NUM_WAYS-1:0] vld,
                                 output logic [hyb_cache_pkg::WORD_W-1:0] data,
                                 output logic [hyb_cache_pkg::NUM_WAYS-1:0] vict);
  logic [hyb_cache_pkg::SET_W-1:0] set;
  set  = line_set(key);
  hit  = '0;
  data = '0;
  vict = '0;
  vld  = m_sa ? m_vld[set] : m_fa_vld;
  for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
    if (m_req && vld[w] &&
        (m_sa ? (m_tag[set][w] == key.sa.tag) : (m_fa_key[w] == key.fa))) begin
      hit[w] = 1'b1;
      data   = m_data[set][w][off*hyb_cache_pkg::WORD_W +: hyb_cache_pkg::WORD_W];
    end
  end
  // First free way counting up or else the pointer
  for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
    if (!vld[w] && (vict == '0)) begin
      vict[w] = 1'b1;
    end
  end
  if (&vld) begin
    vict[m_ptr] = 1'b1;
  end
endfunction

// Accepted line write also moves the pointer
function automatic void store_line(input logic [hyb_cache_pkg::NUM_WAYS-1:0] we,
                                   input hyb_cache_pkg::hyb_key_u key,
                                   input logic [hyb_cache_pkg::NUM_WAYS-1:0] vb,
                                   input logic [hyb_cache_pkg::LINE_W-1:0] data);
  logic [hyb_cache_pkg::SET_W-1:0] set;
  set = line_set(key);
  for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
    if (we[w]) begin
      m_data[set][w] = data;
      if (m_sa) begin
        m_tag[set][w] = key.sa.tag;
        m_vld[set][w] = vb[w];
      end else begin
        m_fa_key[w] = key.fa;
        m_fa_vld[w] = vb[w];
      end
    end
  end
  m_ptr = m_ptr + 1'b1;
endfunction

function automatic void store_word(input logic [hyb_cache_pkg::NUM_WAYS-1:0] we,
                                   input hyb_cache_pkg::hyb_key_u key,
                                   input logic [hyb_cache_pkg::OFF_W-1:0] off,
                                   input logic [hyb_cache_pkg::WORD_W-1:0] data);
  logic [hyb_cache_pkg::SET_W-1:0] set;
  set = line_set(key);
  for (int w = 0; w < hyb_cache_pkg::NUM_WAYS; w++) begin
    if (we[w]) begin
      m_data[set][w][off*hyb_cache_pkg::WORD_W +: hyb_cache_pkg::WORD_W] = data;
    end
  end
endfunction

// Clears the whole array or the reserved region and always the table
function automatic void clear_on_flush();
  for (int s = 0; s < hyb_cache_pkg::NUM_SETS; s++) begin
    if (m_sa || (s >= 48)) begin
      m_vld[s] = '0;
    end
  end
  m_fa_vld = '0;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_hit(input logic [hyb_cache_pkg::NUM_WAYS-1:0] got,
                         input logic [hyb_cache_pkg::NUM_WAYS-1:0] exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
  end
endtask

task automatic check_word(input logic [hyb_cache_pkg::WORD_W-1:0] got,
                          input logic [hyb_cache_pkg::WORD_W-1:0] exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
  end
endtask

task automatic check_flush(input int got, input int exp, input string what);
  if (got != exp) begin
    stop_on_error($sformatf("%s is %0d cycles, expected %0d", what, got, exp));
  end
endtask

`endif

//--- verif/hyb_cache_mem_tb.sv
/* Testbench for the two-mode cache memory, random fills, word writes,
   victim choice and flushes checked against a reference model */
`default_nettype none

module hyb_cache_mem_tb;

  localparam int CLK_PERIOD  = 40;
  // Planned length of all phases, reset included
  localparam int TEST_CYCLES = 300;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 set_assoc_mode_i;
  logic                                 rd_req_i;
  hyb_cache_pkg::hyb_key_u              rd_key_i;
  logic [hyb_cache_pkg::OFF_W-1:0]      rd_off_i;
  logic [hyb_cache_pkg::NUM_WAYS-1:0]   rd_hit_oh_o;
  logic [hyb_cache_pkg::NUM_WAYS-1:0]   rd_vld_bits_o;
  logic [hyb_cache_pkg::WORD_W-1:0]     rd_data_o;
  logic                                 wr_cl_vld_i;
  logic [hyb_cache_pkg::NUM_WAYS-1:0]   wr_cl_we_i;
  hyb_cache_pkg::hyb_key_u              wr_cl_key_i;
  logic [hyb_cache_pkg::NUM_WAYS-1:0]   wr_cl_vld_bits_i;
  logic [hyb_cache_pkg::LINE_W-1:0]     wr_cl_data_i;
  logic [hyb_cache_pkg::NUM_WAYS-1:0]   wr_word_we_i;
  hyb_cache_pkg::hyb_key_u              wr_word_key_i;
  logic [hyb_cache_pkg::OFF_W-1:0]      wr_word_off_i;
  logic [hyb_cache_pkg::WORD_W-1:0]     wr_word_data_i;
  logic                                 flush_i;
  logic                                 flush_ack_o;
  logic [hyb_cache_pkg::NUM_WAYS-1:0]   victim_oh_o;

  // Expected read results handed from stimulus to the checker
  logic [hyb_cache_pkg::NUM_WAYS-1:0]   exp_hit;
  logic [hyb_cache_pkg::NUM_WAYS-1:0]   exp_vld;
  logic [hyb_cache_pkg::NUM_WAYS-1:0]   exp_vict;
  logic [hyb_cache_pkg::WORD_W-1:0]     exp_data;
  int                                   reads_issued = 0;
  int                                   reads_checked = 0;

  logic [31:0]                          rng_state;
  hyb_cache_pkg::hyb_key_u              keys [12];
  hyb_cache_pkg::hyb_key_u              fa_keys [4];

  `include "hyb_cache_model.svh"

  hyb_cache_mem i_hyb_cache_mem (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("Run timed out before all tests finished");
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  task automatic stop_on_error(input string msg);
    $display("MISMATCH at time %0t: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "first error stops the run");
  endtask

  ////////////////////////////////////////////////////////////
  // Random stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [hyb_cache_pkg::LINE_W-1:0] rand_line();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  // Low tag bits carry the index so no two keys share a tag
  function automatic hyb_cache_pkg::hyb_key_u make_key(input int idx);
    hyb_cache_pkg::hyb_key_u k;
    logic [31:0]             r;
    r        = next_rand();
    k.sa.set = r[31:26];
    k.sa.tag = {r[19:4], 4'(idx)};
    return k;
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////

  // One line and/or word write that the model follows at the sampling edge
  task automatic apply_write(input logic cl_en, input logic [3:0] cl_we,
                             input hyb_cache_pkg::hyb_key_u cl_key, input logic [3:0] cl_vb,
                             input logic [hyb_cache_pkg::LINE_W-1:0] cl_data,
                             input logic [3:0] wd_we, input hyb_cache_pkg::hyb_key_u wd_key,
                             input logic [1:0] wd_off, input logic [31:0] wd_data);
    @(posedge clk_i);
    wr_cl_vld_i      <= cl_en;
    wr_cl_we_i       <= cl_we;
    wr_cl_key_i      <= cl_key;
    wr_cl_vld_bits_i <= cl_vb;
    wr_cl_data_i     <= cl_data;
    wr_word_we_i     <= wd_we;
    wr_word_key_i    <= wd_key;
    wr_word_off_i    <= wd_off;
    wr_word_data_i   <= wd_data;
    @(posedge clk_i);
    wr_cl_vld_i  <= 1'b0;
    wr_cl_we_i   <= '0;
    wr_word_we_i <= '0;
    // Line first so the word wins on overlap
    if (cl_en) begin
      store_line(cl_we, cl_key, cl_vb, cl_data);
    end
    store_word(wd_we, wd_key, wd_off, wd_data);
  endtask

  task automatic issue_read(input hyb_cache_pkg::hyb_key_u key, input logic [1:0] off);
    @(posedge clk_i);
    rd_key_i <= key;
    rd_off_i <= off;
    ref_read(key, off, exp_hit, exp_vld, exp_data, exp_vict);
    reads_issued++;
  endtask

  // Flush with a line write dropped inside the walk
  task automatic run_flush(input int n, input hyb_cache_pkg::hyb_key_u drop_key);
    int cnt;
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i          <= 1'b0;
    wr_cl_vld_i      <= 1'b1;
    wr_cl_we_i       <= 4'b0001;
    wr_cl_key_i      <= drop_key;
    wr_cl_vld_bits_i <= '1;
    cnt = 0;
    do begin
      @(posedge clk_i);
      wr_cl_vld_i <= 1'b0;
      wr_cl_we_i  <= '0;
      cnt++;
      @(negedge clk_i);
    end while (!flush_ack_o && (cnt < 2 * n));
    check_flush(cnt, n, "ack delay after flush_i");
    @(negedge clk_i);
    check_flush(flush_ack_o ? 2 : 1, 1, "ack pulse width");
    clear_on_flush();
  endtask

  // Outputs settle by mid cycle
  always @(negedge clk_i) begin
    if (reads_checked != reads_issued) begin
      reads_checked = reads_issued;
      check_hit(rd_hit_oh_o, exp_hit, "hit vector");
      check_hit(rd_vld_bits_o, exp_vld, "valid bits");
      check_hit(victim_oh_o, exp_vict, "victim");
      check_word(rd_data_o, exp_data, "read word");
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    hyb_cache_pkg::hyb_key_u k;
    logic [3:0]              we;
    int                      s;
    int                      fill_way [4] = '{2, 0, 3, 1};
    rng_state = 32'd55742;
    reset_model();
    rst_ni           <= 1'b0;
    set_assoc_mode_i <= 1'b1;
    rd_req_i         <= 1'b0;
    rd_key_i         <= '0;
    rd_off_i         <= '0;
    wr_cl_vld_i      <= 1'b0;
    wr_cl_we_i       <= '0;
    wr_cl_key_i      <= '0;
    wr_cl_vld_bits_i <= '0;
    wr_cl_data_i     <= '0;
    wr_word_we_i     <= '0;
    wr_word_key_i    <= '0;
    wr_word_off_i    <= '0;
    wr_word_data_i   <= '0;
    flush_i          <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni   <= 1'b1;
    rd_req_i <= 1'b1;
    m_req = 1'b1;

    // Set-associative fill and read back
    for (int i = 0; i < 12; i++) begin
      keys[i] = make_key(i);
      we = '0;
      we[i % 4] = 1'b1;
      apply_write(1'b1, we, keys[i], 4'hF, rand_line(), '0, '0, '0, '0);
    end
    for (int i = 0; i < 24; i++) begin
      issue_read(keys[i / 2], 2'(next_rand()));
    end

    // Stored keys without a request never hit
    @(posedge clk_i);
    rd_req_i <= 1'b0;
    m_req = 1'b0;
    for (int i = 0; i < 4; i++) begin
      issue_read(keys[i], 2'(i));
    end
    @(posedge clk_i);
    rd_req_i <= 1'b1;
    m_req = 1'b1;

    // Same set with another tag
    for (int i = 0; i < 12; i++) begin
      k = keys[i];
      k.sa.tag[19] = ~k.sa.tag[19];
      issue_read(k, 2'(next_rand()));
    end
    for (int i = 0; i < 6; i++) begin
      we = '0;
      we[i % 4] = 1'b1;
      apply_write(1'b0, '0, '0, '0, '0, we, keys[i], 2'(next_rand()), next_rand());
    end
    for (int i = 0; i < 24; i++) begin
      issue_read(keys[i / 4], 2'(i));
    end
    // Line and word on one way in one cycle
    apply_write(1'b1, 4'b0100, keys[6], 4'hF, rand_line(), 4'b0100, keys[6], 2'd1, next_rand());
    for (int o = 0; o < 4; o++) begin
      issue_read(keys[6], 2'(o));
    end
    // Line write that clears valid
    apply_write(1'b1, 4'b1000, keys[7], 4'h0, rand_line(), '0, '0, '0, '0);
    issue_read(keys[7], 2'd0);

    // Victim over an empty set and round robin once full
    s = 0;
    while (m_vld[s] != '0) begin
      s++;
    end
    for (int i = 0; i < 8; i++) begin
      k = make_key(12 + i);
      k.sa.set = 6'(s);
      we = '0;
      we[fill_way[i % 4]] = 1'b1;
      apply_write(1'b1, we, k, 4'hF, rand_line(), '0, '0, '0, '0);
      issue_read(k, 2'(i));
    end

    // Set-associative flush
    run_flush(64, keys[1]);
    for (int i = 0; i < 12; i++) begin
      issue_read(keys[i], 2'd0);
    end

    // Fully-associative table
    @(posedge clk_i);
    set_assoc_mode_i <= 1'b0;
    m_sa = 1'b0;
    for (int i = 0; i < 4; i++) begin
      fa_keys[i] = make_key(20 + i);
      we = '0;
      we[i] = 1'b1;
      apply_write(1'b1, we, fa_keys[i], 4'hF, rand_line(), '0, '0, '0, '0);
    end
    for (int i = 0; i < 8; i++) begin
      issue_read(fa_keys[i / 2], 2'(next_rand()));
    end
    for (int i = 0; i < 4; i++) begin
      k = fa_keys[i];
      k.fa[25:20] = ~k.fa[25:20];
      issue_read(k, 2'd0);
    end

    // Fully-associative flush
    run_flush(16, fa_keys[0]);
    for (int i = 0; i < 4; i++) begin
      issue_read(fa_keys[i], 2'd0);
    end

    @(posedge clk_i);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verif
design/hyb_cache_pkg.sv
design/hyb_tag_store.sv
design/hyb_data_store.sv
design/hyb_victim_select.sv
design/hyb_flush_ctrl.sv
design/hyb_cache_mem.sv
verif/hyb_cache_mem_tb.sv

//--- Makefile
# Verilator build and run of the cache memory testbench
VERILATOR ?= verilator
TOP       ?= hyb_cache_mem_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
